/* Bender.yml */
package:
  name: rv32i_core

sources:
  - hw/core_pkg.sv
  - hw/lsu_req_if.sv
  - hw/core_idu.sv
  - hw/core_regfile.sv
  - hw/core_exu.sv
  - hw/core_lsu.sv
  - hw/core_pc.sv
  - hw/core_top.sv
  - target: test
    files:
      - verification/core_tb.sv

/* hw/core_exu.sv */
`default_nettype none

module core_exu import core_pkg::*; (
    input  wire inst_kind_e       kind,
    input  wire logic [xlen-1:0]  pc,
    input  wire logic [xlen-1:0]  rdata1,
    input  wire logic [xlen-1:0]  rdata2,
    input  wire logic [xlen-1:0]  imm,
    output logic                  reg_wen,
    output logic      [xlen-1:0]  wb_data,
    output logic                  jump,
    output logic      [xlen-1:0]  jump_target,
    output logic                  halt_req,
    lsu_req_if.exu_side           lsu
);

    logic [xlen-1:0] sum_ri;   // rs1 + imm, shared adder
    logic [xlen-1:0] result;   // value for rd unless load

    assign sum_ri = rdata1 + imm;

    // --------------------------------------------------
    // per-kind control and datapath
    // --------------------------------------------------
    always_comb begin
        result      = '0;
        reg_wen     = 1'b0;
        jump        = 1'b0;
        jump_target = '0;
        halt_req    = 1'b0;
        lsu.addr    = '0;
        lsu.rd_en   = 1'b0;
        lsu.wr_en   = 1'b0;
        lsu.size    = size_word;
        lsu.wdata   = '0;
        case (kind)
            kind_addi: begin
                result  = sum_ri;
                reg_wen = 1'b1;
            end
            kind_jalr: begin
                jump_target = {sum_ri[xlen-1:1], 1'b0};  // bit 0 cleared
                jump        = 1'b1;
                result      = pc + 32'd4;                // link
                reg_wen     = 1'b1;
            end
            kind_ebreak: halt_req = 1'b1;  // no write back
            kind_add: begin
                result  = rdata1 + rdata2;
                reg_wen = 1'b1;
            end
            kind_lui: begin
                result  = imm;               // already shifted by idu
                reg_wen = 1'b1;
            end
            kind_lw, kind_lbu: begin
                lsu.addr  = sum_ri;
                lsu.rd_en = 1'b1;
                lsu.size  = (kind == kind_lw) ? size_word : size_byte;
                reg_wen   = 1'b1;
            end
            kind_sw, kind_sb: begin
                lsu.addr  = sum_ri;
                lsu.wr_en = 1'b1;
                lsu.size  = (kind == kind_sw) ? size_word : size_byte;
                lsu.wdata = rdata2;          // lsu replicates bytes
            end
            default: ;                       // none, nothing happens
        endcase
    end

    // loads write back what the lsu returns
    assign wb_data = lsu.rd_en ? lsu.load_data : result;

endmodule

`default_nettype wire

/* hw/core_idu.sv */
`default_nettype none

module core_idu import core_pkg::*; (
    input  wire logic [xlen-1:0]       inst,
    output inst_kind_e                 kind,
    output logic      [reg_addr_w-1:0] rs1,
    output logic      [reg_addr_w-1:0] rs2,
    output logic      [reg_addr_w-1:0] rd,
    output logic      [xlen-1:0]       imm
);

    // --------------------------------------------------
    // instruction fields
    // --------------------------------------------------
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic [xlen-1:0] imm_i;  // addi, jalr, loads
    logic [xlen-1:0] imm_s;  // stores
    logic [xlen-1:0] imm_u;  // lui

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // register indices straight from the word
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // sign-extended immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};   // low bits zero

    // --------------------------------------------------
    // kind decode, exactly one hot or none
    // --------------------------------------------------
    always_comb begin
        kind = kind_none;
        case (opcode)
            op_imm: begin
                if (funct3 == f3_zero) kind = kind_addi;
            end
            op_jalr: begin
                if (funct3 == f3_zero) kind = kind_jalr;
            end
            op_system: begin
                // full match, ecall and csr ops stay unrecognised
                if (inst[31:20] == imm_ebreak && funct3 == f3_zero &&
                    rs1 == '0 && rd == '0) begin
                    kind = kind_ebreak;
                end
            end
            op_reg: begin
                if (funct3 == f3_zero && funct7 == f7_add) kind = kind_add;  // not sub
            end
            op_lui: kind = kind_lui;
            op_load: begin
                if (funct3 == f3_word)        kind = kind_lw;
                else if (funct3 == f3_byte_u) kind = kind_lbu;
            end
            op_store: begin
                if (funct3 == f3_word)      kind = kind_sw;
                else if (funct3 == f3_byte) kind = kind_sb;
            end
            default: kind = kind_none;
        endcase
    end

    // immediate format follows the kind
    always_comb begin
        case (kind)
            kind_addi,
            kind_jalr,
            kind_lw,
            kind_lbu:  imm = imm_i;
            kind_sw,
            kind_sb:   imm = imm_s;
            kind_lui:  imm = imm_u;
            default:   imm = '0;   // add, ebreak, none
        endcase
    end

endmodule

`default_nettype wire

/* hw/core_lsu.sv */
`default_nettype none

module core_lsu import core_pkg::*; (
    lsu_req_if.lsu_side           lsu,
    output logic      [xlen-1:0]  dmem_addr,
    output logic                  dmem_ren,
    output logic                  dmem_wen,
    output logic      [3:0]       dmem_wmask,
    output logic      [xlen-1:0]  dmem_wdata,
    input  wire logic [xlen-1:0]  dmem_rdata
);

    logic [1:0] byte_off;   // lane within the word
    logic [7:0] load_byte;  // selected lane for lbu

    assign byte_off = lsu.addr[1:0];

    // word aligned, misaligned words just drop low bits
    assign dmem_addr = {lsu.addr[xlen-1:2], 2'b00};
    assign dmem_ren  = lsu.rd_en;
    assign dmem_wen  = lsu.wr_en;

    // --------------------------------------------------
    // store side
    // --------------------------------------------------
    always_comb begin
        if (!lsu.wr_en) begin
            dmem_wmask = 4'b0000;
            dmem_wdata = lsu.wdata;
        end else if (lsu.size == size_word) begin
            dmem_wmask = 4'b1111;
            dmem_wdata = lsu.wdata;
        end else begin
            dmem_wmask = 4'b0001 << byte_off;      // one lane
            dmem_wdata = {4{lsu.wdata[7:0]}};      // byte in every lane
        end
    end

    // --------------------------------------------------
    // load side
    // --------------------------------------------------
    always_comb begin
        case (byte_off)
            2'd0:    load_byte = dmem_rdata[7:0];
            2'd1:    load_byte = dmem_rdata[15:8];
            2'd2:    load_byte = dmem_rdata[23:16];
            default: load_byte = dmem_rdata[31:24];
        endcase
    end

    // lbu zero-extends, lw passes the word
    assign lsu.load_data = (lsu.size == size_word) ? dmem_rdata
                                                   : {{(xlen-8){1'b0}}, load_byte};

endmodule

`default_nettype wire

/* hw/core_pc.sv */
`default_nettype none

module core_pc import core_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             jump,
    input  wire logic [xlen-1:0]  jump_target,
    input  wire logic             halt_req,
    output logic      [xlen-1:0]  pc,
    output logic                  halt
);

    logic [xlen-1:0] next_pc;
    logic            hold;      // ebreak now or earlier

    assign hold    = halt_req | halt;
    assign next_pc = jump ? jump_target : pc + 32'd4;

    // --------------------------------------------------
    // pc and sticky halt
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= reset_pc;
            halt <= 1'b0;
        end else begin
            if (halt_req) halt <= 1'b1;   // only reset clears
            if (!hold) pc <= next_pc;     // frozen on ebreak
        end
    end

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

    // --------------------------------------------------
    // machine widths
    // --------------------------------------------------
    localparam int xlen       = 32;           // data and address width
    localparam int reg_count  = 32;           // x0 .. x31
    localparam int reg_addr_w = 5;            // log2(reg_count)

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;  // first fetch address

    // one-hot instruction kind, bit order as in the execute unit
    typedef enum logic [8:0] {
        kind_none   = 9'b000000000,  // not recognised, no side effects
        kind_addi   = 9'b000000001,
        kind_jalr   = 9'b000000010,
        kind_ebreak = 9'b000000100,
        kind_add    = 9'b000001000,
        kind_lui    = 9'b000010000,
        kind_lw     = 9'b000100000,
        kind_lbu    = 9'b001000000,
        kind_sw     = 9'b010000000,
        kind_sb     = 9'b100000000
    } inst_kind_e;

    // --------------------------------------------------
    // rv32i major opcodes, inst[6:0]
    // --------------------------------------------------
    localparam logic [6:0] op_imm    = 7'b0010011;  // addi
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_system = 7'b1110011;  // ebreak
    localparam logic [6:0] op_reg    = 7'b0110011;  // add
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;  // lw, lbu
    localparam logic [6:0] op_store  = 7'b0100011;  // sw, sb

    // funct3 / funct7 fields
    localparam logic [2:0] f3_zero   = 3'b000;      // addi, add, jalr, ebreak
    localparam logic [2:0] f3_byte   = 3'b000;      // sb
    localparam logic [2:0] f3_byte_u = 3'b100;      // lbu
    localparam logic [2:0] f3_word   = 3'b010;      // lw, sw
    localparam logic [6:0] f7_add    = 7'b0000000;

    // ebreak is I-type with imm = 1, rs1 = rd = 0
    localparam logic [11:0] imm_ebreak = 12'h001;

    // access size seen by the load/store unit
    typedef enum logic {
        size_byte = 1'b0,
        size_word = 1'b1
    } mem_size_e;

endpackage

`default_nettype wire

/* hw/core_regfile.sv */
`default_nettype none

module core_regfile import core_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [reg_addr_w-1:0] rs1,
    input  wire logic [reg_addr_w-1:0] rs2,
    output logic      [xlen-1:0]       rdata1,
    output logic      [xlen-1:0]       rdata2,
    input  wire logic                  wen,
    input  wire logic [reg_addr_w-1:0] rd,
    input  wire logic [xlen-1:0]       wdata
);

    logic [xlen-1:0] regs [reg_count];

    // --------------------------------------------------
    // write port, edge triggered
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin  // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    // read ports, combinational, x0 hardwired
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hw/core_top.sv */
`default_nettype none

module core_top import core_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    output logic      [xlen-1:0]  imem_addr,
    input  wire logic [xlen-1:0]  imem_rdata,
    output logic      [xlen-1:0]  dmem_addr,
    output logic                  dmem_ren,
    output logic                  dmem_wen,
    output logic      [3:0]       dmem_wmask,
    output logic      [xlen-1:0]  dmem_wdata,
    input  wire logic [xlen-1:0]  dmem_rdata,
    output logic                  halt
);

    // --------------------------------------------------
    // internal nets
    // --------------------------------------------------
    inst_kind_e            kind;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic                  reg_wen;
    logic [xlen-1:0]       wb_data;
    logic                  jump;
    logic [xlen-1:0]       jump_target;
    logic                  halt_req;

    lsu_req_if lsu_req ();   // exu -> lsu

    // fetch address is the pc itself
    core_pc u_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .jump        (jump),
        .jump_target (jump_target),
        .halt_req    (halt_req),
        .pc          (imem_addr),
        .halt        (halt)
    );

    core_idu u_idu (
        .inst (imem_rdata),
        .kind (kind),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm)
    );

    core_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (reg_wen),
        .rd     (rd),
        .wdata  (wb_data)
    );

    core_exu u_exu (
        .kind        (kind),
        .pc          (imem_addr),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm         (imm),
        .reg_wen     (reg_wen),
        .wb_data     (wb_data),
        .jump        (jump),
        .jump_target (jump_target),
        .halt_req    (halt_req),
        .lsu         (lsu_req.exu_side)
    );

    core_lsu u_lsu (
        .lsu        (lsu_req.lsu_side),
        .dmem_addr  (dmem_addr),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

/* hw/lsu_req_if.sv */
`default_nettype none

// one data-memory request per cycle, no handshake
interface lsu_req_if import core_pkg::*; ();

    logic [xlen-1:0] addr;       // byte address, unaligned
    logic            rd_en;      // load this cycle
    logic            wr_en;      // store this cycle
    mem_size_e       size;       // byte or word
    logic [xlen-1:0] wdata;      // store data, lane 0 aligned
    logic [xlen-1:0] load_data;  // extended load result, same cycle

    // execute side issues, gets load data back
    modport exu_side (
        output addr, rd_en, wr_en, size, wdata,
        input  load_data
    );

    // load/store unit side
    modport lsu_side (
        input  addr, rd_en, wr_en, size, wdata,
        output load_data
    );

endinterface

`default_nettype wire

/* sources.f */
hw/core_pkg.sv
hw/lsu_req_if.sv
hw/core_idu.sv
hw/core_regfile.sv
hw/core_exu.sv
hw/core_lsu.sv
hw/core_pc.sv
hw/core_top.sv
verification/core_tb.sv

/* verification/core_tb.sv */
`default_nettype none

module core_tb;

    localparam logic [31:0] boot_pc = 32'h8000_0000;  // pc after reset
    localparam logic [31:0] d_base  = 32'h0000_1000;  // 256-byte data window

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic [3:0]  dmem_wmask;
    logic        dmem_ren;
    logic        dmem_wen;
    logic        halt;

    logic [31:0] imem [256];     // program, word per entry
    logic [7:0]  dmem [256];     // bytes at d_base
    logic [7:0]  m_mem [256];    // model copy of dmem
    logic [31:0] m_regs [32];    // model register file
    logic [31:0] exp_pc [$];     // fetch order
    logic        exp_ren [$];    // load expected, one per fetch
    logic [31:0] exp_addr [$];   // expected stores, in order
    logic [31:0] exp_data [$];
    logic [3:0]  exp_mask [$];
    logic [31:0] lcg_state = 32'hc365;
    logic [31:0] halt_pc;        // address of the ebreak
    int          prog_len;
    int          m_stores;
    int          seen_stores;
    int          errors;
    int          first_err;      // error count when the test began
    int          test_no;
    time         wd_start;
    time         wd_limit;
    logic        wd_armed = 1'b0;

    core_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // memory models
    // --------------------------------------------------
    assign imem_rdata = imem[imem_addr[9:2]];   // boot_pc has zero low bits
    assign dmem_rdata = {dmem[{dmem_addr[7:2], 2'd3}], dmem[{dmem_addr[7:2], 2'd2}],
                         dmem[{dmem_addr[7:2], 2'd1}], dmem[{dmem_addr[7:2], 2'd0}]};

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_wen && dmem_wmask[b]) begin
                dmem[{dmem_addr[7:2], b[1:0]}] <= dmem_wdata[8*b +: 8];  // masked lane
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic load_data_memory();
        logic [31:0] r;
        for (int i = 0; i < 256; i++) begin
            r = lcg_next();
            dmem[i]  = r[31:24];   // high lcg bits, less regular
            m_mem[i] = r[31:24];
        end
    endtask

    // --------------------------------------------------
    // program builder and reference model
    // --------------------------------------------------
    task automatic append_word(input logic [31:0] w);   // reached in order
        exp_pc.push_back(boot_pc + 4 * prog_len);
        exp_ren.push_back(1'b0);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic pad_word(input logic [31:0] w);      // placed, never fetched
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 0) m_regs[rd] = v;   // x0 stays zero
    endtask

    task automatic lui_insn(input logic [4:0] rd, input logic [19:0] imm);
        append_word({imm, rd, 7'b0110111});
        set_reg(rd, {imm, 12'h000});
    endtask

    task automatic addi_insn(input logic [4:0] rd, rs1, input logic [11:0] imm);
        append_word({imm, rs1, 3'b000, rd, 7'b0010011});
        set_reg(rd, m_regs[rs1] + sext12(imm));
    endtask

    task automatic add_insn(input logic [4:0] rd, rs1, rs2);
        append_word({7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011});
        set_reg(rd, m_regs[rs1] + m_regs[rs2]);
    endtask

    task automatic load_insn(input logic is_byte, input logic [4:0] rd, rs1,
                             input logic [11:0] imm);
        logic [31:0] a;
        a = m_regs[rs1] + sext12(imm);
        append_word({imm, rs1, is_byte ? 3'b100 : 3'b010, rd, 7'b0000011});
        exp_ren[exp_ren.size() - 1] = 1'b1;   // read strobe in this cycle
        if (is_byte) begin
            set_reg(rd, {24'h0, m_mem[a[7:0]]});   // lbu, zero extended
        end else begin
            set_reg(rd, {m_mem[{a[7:2], 2'd3}], m_mem[{a[7:2], 2'd2}],
                         m_mem[{a[7:2], 2'd1}], m_mem[{a[7:2], 2'd0}]});
        end
    endtask

    task automatic store_insn(input logic is_byte, input logic [4:0] rs2, rs1,
                              input logic [11:0] imm);
        logic [31:0] a;
        logic [31:0] v;
        a = m_regs[rs1] + sext12(imm);
        v = m_regs[rs2];
        append_word({imm[11:5], rs2, rs1, is_byte ? 3'b000 : 3'b010, imm[4:0], 7'b0100011});
        exp_addr.push_back({a[31:2], 2'b00});   // memory sees the word address
        if (is_byte) begin
            exp_mask.push_back(4'b0001 << a[1:0]);
            exp_data.push_back({4{v[7:0]}});    // byte copied to every lane
            m_mem[a[7:0]] = v[7:0];
        end else begin
            exp_mask.push_back(4'b1111);
            exp_data.push_back(v);
            for (int b = 0; b < 4; b++) m_mem[{a[7:2], b[1:0]}] = v[8*b +: 8];
        end
        m_stores++;
    endtask

    task automatic jalr_insn(input logic [4:0] rd, rs1, input logic [11:0] imm,
                             input logic [31:0] skipped);
        logic [31:0] target;
        logic [31:0] link;
        target = (m_regs[rs1] + sext12(imm)) & ~32'h1;   // bit 0 dropped
        link   = boot_pc + 4 * prog_len + 4;
        append_word({imm, rs1, 3'b000, rd, 7'b1100111});
        set_reg(rd, link);
        while (boot_pc + 4 * prog_len < target) pad_word(skipped);
    endtask

    task automatic ebreak_insn();
        halt_pc = boot_pc + 4 * prog_len;
        append_word(32'h0010_0073);
    endtask

    // --------------------------------------------------
    // test sequencing
    // --------------------------------------------------
    task automatic begin_test();
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);   // core in reset, memories safe to rewrite
        prog_len    = 0;
        m_stores    = 0;
        seen_stores = 0;
        first_err   = errors;
        test_no++;
        exp_pc.delete();
        exp_ren.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_mask.delete();
        for (int r = 0; r < 32; r++) m_regs[r] = '0;
        load_data_memory();
    endtask

    task automatic end_test(input string name);
        $display("[%0d] %s: %s", test_no, name, (errors == first_err) ? "ok" : "errors");
    endtask

    task automatic check_reset_state();
        compare_value("imem_addr", boot_pc, imem_addr);
        compare_value("halt", 0, halt);
        compare_value("dmem_wen", 0, dmem_wen);
    endtask

    task automatic check_cycle();   // one executed instruction
        assert (exp_pc.size() > 0) else report_problem("core kept running past its ebreak");
        if (exp_pc.size() > 0) begin
            compare_value("imem_addr", exp_pc.pop_front(), imem_addr);
            compare_value("dmem_ren", exp_ren.pop_front(), dmem_ren);
        end
        if (dmem_wen) begin
            seen_stores++;
            assert (exp_addr.size() > 0) else report_problem("store the model never issued");
            if (exp_addr.size() > 0) begin
                compare_value("dmem_addr", exp_addr.pop_front(), dmem_addr);
                compare_value("dmem_wdata", exp_data.pop_front(), dmem_wdata);
                compare_value("dmem_wmask", exp_mask.pop_front(), dmem_wmask);
            end
        end
    endtask

    task automatic run_program();
        check_reset_state();
        repeat (2) begin
            @(negedge clk);
            check_reset_state();
        end
        @(posedge clk);
        rst_n    <= 1'b1;
        wd_start = $time;
        wd_limit = (prog_len + 20) * 20;
        wd_armed = 1'b1;
        @(negedge clk);
        check_reset_state();   // first cycle out of reset
        while (!halt) begin
            check_cycle();
            @(negedge clk);
        end
        assert (exp_pc.size() == 0) else report_problem("halt rose before the ebreak ran");
        while ($time - wd_start < wd_limit) begin   // parked on the ebreak
            compare_value("halt", 1, halt);
            compare_value("imem_addr", halt_pc, imem_addr);
            compare_value("dmem_wen", 0, dmem_wen);
            compare_value("dmem_ren", 0, dmem_ren);
            @(negedge clk);
        end
        wd_armed = 1'b0;
        compare_value("store count", m_stores, seen_stores);
        for (int w = 0; w < 256; w += 4) begin
            compare_value($sformatf("dmem word %0d", w / 4),
                          {m_mem[w+3], m_mem[w+2], m_mem[w+1], m_mem[w]},
                          {dmem[w+3], dmem[w+2], dmem[w+1], dmem[w]});
        end
    endtask

    initial begin
        logic [31:0] r;
        rst_n   = 1'b0;
        errors  = 0;
        test_no = 0;
        imem[0] = 32'h0000_0013;   // nop until a program is loaded
        load_data_memory();

        begin_test();
        lui_insn(1, d_base[31:12]);
        addi_insn(2, 0, 12'h005);
        ebreak_insn();
        run_program();
        end_test("reset");

        begin_test();
        r = lcg_next();
        lui_insn(1, d_base[31:12]);     // x1 = d_base
        lui_insn(2, r[31:12]);
        r = lcg_next();
        addi_insn(3, 2, r[11:0]);
        addi_insn(4, 0, r[23:12]);
        add_insn(5, 3, 4);
        add_insn(6, 5, 2);
        addi_insn(0, 3, r[31:20]);  // dropped by x0
        add_insn(7, 0, 5);
        for (int k = 2; k < 8; k++) store_insn(0, k[4:0], 1, 12'(4 * k));
        store_insn(0, 0, 1, 12'h020);
        ebreak_insn();
        run_program();
        end_test("arithmetic and write-back");

        begin_test();
        lui_insn(1, d_base[31:12]);
        for (int k = 0; k < 4; k++) begin
            r = lcg_next();
            addi_insn(2, 0, r[11:0]);
            store_insn(1, 2, 1, 12'(8'h40 + k));   // lanes 0 to 3
        end
        load_insn(0, 3, 1, 12'h040);
        store_insn(0, 3, 1, 12'h044);
        ebreak_insn();
        run_program();
        end_test("byte stores");

        begin_test();
        r = lcg_next();
        dmem[8'h81]  = r[7:0] | 8'h80;   // sign bit set, must not extend
        m_mem[8'h81] = dmem[8'h81];
        lui_insn(1, d_base[31:12]);
        load_insn(0, 2, 1, 12'h080);
        store_insn(0, 2, 1, 12'h090);
        for (int k = 0; k < 4; k++) begin
            load_insn(1, 3, 1, 12'(8'h80 + k));
            store_insn(0, 3, 1, 12'(8'h94 + 4 * k));
        end
        ebreak_insn();
        run_program();
        end_test("loads");

        begin_test();
        lui_insn(1, d_base[31:12]);
        lui_insn(5, 20'h80000);          // x5 = boot_pc
        // two words ahead, odd offset
        jalr_insn(6, 5, 12'(4 * prog_len + 9),
                  {7'h00, 5'd5, 5'd1, 3'b010, 5'h10, 7'b0100011});
        store_insn(0, 6, 1, 12'h000);    // link value
        addi_insn(7, 0, 12'h123);
        store_insn(0, 7, 1, 12'h004);
        ebreak_insn();
        run_program();
        end_test("jalr");

        begin_test();
        r = lcg_next();
        lui_insn(1, d_base[31:12]);
        addi_insn(2, 0, r[11:0]);
        store_insn(0, 2, 1, 12'h008);
        ebreak_insn();
        pad_word({7'h00, 5'd2, 5'd1, 3'b010, 5'h0c, 7'b0100011});  // behind the ebreak
        run_program();
        end_test("ebreak");

        $display("%0d tests run, %0d errors", test_no, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, limit set per program
    initial begin
        @(posedge clk);
        while (!(wd_armed && ($time - wd_start > wd_limit))) @(posedge clk);
        $display("timeout: core did not halt within %0t time units after reset", wd_limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
